/* Makefile */
# Verilator build and run of the memory stage testbench
VERILATOR ?= verilator
TOP       ?= memStageTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)

check: run
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* all.f */
src/memAccessPkg.sv
src/ramPkg.sv
src/storePath.sv
src/loadPath.sv
src/memArbiter.sv
src/dataRam.sv
src/memStage.sv
dv/memStageTb.sv

/* dv/memStageTb.sv */
// testbench that runs random load and store traffic on memStage against a shadow memory
`timescale 1ns/1ns
`default_nettype none

module memStageTb;

  import memAccessPkg::*;
  import ramPkg::*;

  localparam int Timeout  = 50;
  localparam int TxnCount = 300;

  logic                 clk;
  logic                 reset;
  logic                 storeReq;
  logic [DataWidth-1:0] storeAddr;
  logic [SizeWidth-1:0] storeSize;
  logic [DataWidth-1:0] storeData;
  logic                 storeBusy;
  logic                 storeDone;
  logic                 storeAddrErr;
  logic                 loadReq;
  logic [DataWidth-1:0] loadAddr;
  logic [SizeWidth-1:0] loadSize;
  logic                 loadSigned;
  logic                 loadBusy;
  logic                 loadDone;
  logic [DataWidth-1:0] loadData;
  logic                 loadAddrErr;
  logic [31:0]          lfsr;
  logic [DataWidth-1:0] shadow [RamDepth];

  memStage u_memStage (
    .clk          (clk),
    .reset        (reset),
    .storeReq     (storeReq),
    .storeAddr    (storeAddr),
    .storeSize    (storeSize),
    .storeData    (storeData),
    .storeBusy    (storeBusy),
    .storeDone    (storeDone),
    .storeAddrErr (storeAddrErr),
    .loadReq      (loadReq),
    .loadAddr     (loadAddr),
    .loadSize     (loadSize),
    .loadSigned   (loadSigned),
    .loadBusy     (loadBusy),
    .loadDone     (loadDone),
    .loadData     (loadData),
    .loadAddrErr  (loadAddrErr)
  );

  always #50 clk = ~clk;

  // **************************************************************************
  // random source and reference model
  // **************************************************************************

  // the taps are 32, 22, 2 and 1 and the register steps once per bit handed out
  function automatic logic [31:0] nextBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr     = {lfsr[30:0], feedback};
      value    = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic logic [SizeWidth-1:0] randomSize();
    logic [31:0] raw;
    raw = nextBits(2);
    return (raw == 32'd3) ? SizeWord : raw[SizeWidth-1:0];
  endfunction

  // addresses stay in the first 64 words and are mostly aligned so that most requests reach the RAM
  function automatic logic [DataWidth-1:0] randomAddr(input logic [SizeWidth-1:0] size);
    logic [DataWidth-1:0] addr;
    addr = nextBits(8);
    if (nextBits(2) != 32'd0) begin
      if (size == SizeHalf) addr[0] = 1'b0;
      if (size == SizeWord) addr[1:0] = 2'b00;
    end
    return addr;
  endfunction

  function automatic logic isMisaligned(input logic [SizeWidth-1:0] size,
                                        input logic [DataWidth-1:0] addr);
    return (size == SizeHalf && addr[0]) || (size == SizeWord && addr[1:0] != 2'b00);
  endfunction

  // data is shifted to its lane and only the addressed bytes of the shadow word change
  task automatic applyStore(input logic [DataWidth-1:0] addr, input logic [SizeWidth-1:0] size,
                            input logic [DataWidth-1:0] data);
    logic [DataWidth-1:0] placed;
    logic [3:0]           mask;
    case (size)
      SizeByte: begin
        placed = {24'b0, data[7:0]} << (8 * addr[1:0]);
        mask   = 4'b0001 << addr[1:0];
      end
      SizeHalf: begin
        placed = {16'b0, data[15:0]} << (16 * addr[1]);
        mask   = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        placed = data;
        mask   = 4'b1111;
      end
    endcase
    for (int lane = 0; lane < 4; lane++) begin
      if (mask[lane]) shadow[addr[WordAddrWidth+1:2]][8*lane +: 8] = placed[8*lane +: 8];
    end
  endtask

  function automatic logic [DataWidth-1:0] expectLoad(input logic [DataWidth-1:0] addr,
                                                      input logic [SizeWidth-1:0] size,
                                                      input logic isSigned);
    logic [DataWidth-1:0] word;
    word = shadow[addr[WordAddrWidth+1:2]];
    if (size == SizeByte) begin
      word = word >> (8 * addr[1:0]);
      word = {{24{isSigned & word[7]}}, word[7:0]};
    end else if (size == SizeHalf) begin
      word = word >> (16 * addr[1]);
      word = {{16{isSigned & word[15]}}, word[15:0]};
    end
    return word;
  endfunction

  // **************************************************************************
  // checks
  // **************************************************************************

  task automatic checkWord(input ramWord expected, input ramWord actual, input string what);
    if (actual !== expected) begin
      $display("Error: at %0t ns, %s: expected %h, got %h", $time, what, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic checkFlag(input logic expected, input logic actual, input string what);
    if (actual !== expected) begin
      $display("Error: at %0t ns, %s: expected %b, got %b", $time, what, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("%s did not finish within %0d cycles", what, Timeout);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // **************************************************************************
  // transactions
  // **************************************************************************

  task automatic doStore(input logic [DataWidth-1:0] addr, input logic [SizeWidth-1:0] size,
                         input logic [DataWidth-1:0] data);
    int   cycles;
    logic expectErr;
    expectErr = isMisaligned(size, addr);
    cycles    = 0;
    @(posedge clk);
    storeReq  <= 1'b1;
    storeAddr <= addr;
    storeSize <= size;
    storeData <= data;
    @(posedge clk);
    storeReq <= 1'b0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles == 1) checkFlag(!expectErr, storeBusy, "store busy after request");
    end while (!storeDone && !storeAddrErr && cycles < Timeout);
    if (!storeDone && !storeAddrErr) reportTimeout("store");
    checkFlag(expectErr, storeAddrErr, "store address error");
    checkFlag(1'b0, storeBusy, "store busy at completion");
    // the error comes one cycle after the request and done comes three cycles after it
    checkFlag(1'b1, cycles == (expectErr ? 1 : 3), "store latency");
    if (expectErr) begin
      repeat (3) begin
        @(negedge clk);
        checkFlag(1'b0, storeDone, "store done after address error");
      end
    end else begin
      applyStore(addr, size, data);
    end
  endtask

  task automatic doLoad(input logic [DataWidth-1:0] addr, input logic [SizeWidth-1:0] size,
                        input logic isSigned);
    int                   cycles;
    logic                 expectErr;
    logic [DataWidth-1:0] expected;
    expectErr = isMisaligned(size, addr);
    expected  = expectLoad(addr, size, isSigned);
    cycles    = 0;
    @(posedge clk);
    loadReq    <= 1'b1;
    loadAddr   <= addr;
    loadSize   <= size;
    loadSigned <= isSigned;
    @(posedge clk);
    loadReq <= 1'b0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles == 1) checkFlag(!expectErr, loadBusy, "load busy after request");
    end while (!loadDone && !loadAddrErr && cycles < Timeout);
    if (!loadDone && !loadAddrErr) reportTimeout("load");
    checkFlag(expectErr, loadAddrErr, "load address error");
    checkFlag(1'b0, loadBusy, "load busy at completion");
    checkFlag(1'b1, cycles == (expectErr ? 1 : 4), "load latency");
    if (expectErr) begin
      repeat (3) begin
        @(negedge clk);
        checkFlag(1'b0, loadDone, "load done after address error");
      end
    end else begin
      checkWord(expected, loadData, "load data");
    end
  endtask

  // both ports pulse in the same cycle and the load sees memory as it was before the store
  task automatic doBoth(input logic [DataWidth-1:0] sAddr, input logic [SizeWidth-1:0] sSize,
                        input logic [DataWidth-1:0] sData, input logic [DataWidth-1:0] lAddr,
                        input logic [SizeWidth-1:0] lSize, input logic lSigned);
    int                   cycles;
    logic                 storeSeen;
    logic                 loadSeen;
    logic [DataWidth-1:0] otherAddr;
    logic [DataWidth-1:0] expected;
    otherAddr = lAddr;
    if (otherAddr[WordAddrWidth+1:2] == sAddr[WordAddrWidth+1:2]) otherAddr[2] = ~otherAddr[2];
    expected  = expectLoad(otherAddr, lSize, lSigned);
    cycles    = 0;
    storeSeen = 1'b0;
    loadSeen  = 1'b0;
    @(posedge clk);
    storeReq   <= 1'b1;
    storeAddr  <= sAddr;
    storeSize  <= sSize;
    storeData  <= sData;
    loadReq    <= 1'b1;
    loadAddr   <= otherAddr;
    loadSize   <= lSize;
    loadSigned <= lSigned;
    @(posedge clk);
    storeReq <= 1'b0;
    loadReq  <= 1'b0;
    while (!(storeSeen && loadSeen) && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
      if (storeDone || storeAddrErr) begin
        storeSeen = 1'b1;
        checkFlag(isMisaligned(sSize, sAddr), storeAddrErr, "concurrent store address error");
      end
      if (loadDone || loadAddrErr) begin
        loadSeen = 1'b1;
        checkFlag(isMisaligned(lSize, otherAddr), loadAddrErr, "concurrent load address error");
        if (loadDone) checkWord(expected, loadData, "concurrent load data");
      end
    end
    if (!(storeSeen && loadSeen)) reportTimeout("concurrent store and load");
    if (!isMisaligned(sSize, sAddr)) applyStore(sAddr, sSize, sData);
  endtask

  // a second pulse while the first store is still busy must leave no trace
  task automatic storeWhileBusy(input logic [DataWidth-1:0] first,
                                input logic [DataWidth-1:0] other);
    int cycles;
    cycles = 0;
    @(posedge clk);
    storeReq  <= 1'b1;
    storeAddr <= 32'h40;
    storeSize <= SizeWord;
    storeData <= first;
    @(posedge clk);
    storeReq <= 1'b0;
    @(negedge clk);
    checkFlag(1'b1, storeBusy, "store busy after request");
    @(posedge clk);
    storeReq  <= 1'b1;
    storeAddr <= 32'h44;
    storeData <= other;
    @(posedge clk);
    storeReq <= 1'b0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!storeDone && cycles < Timeout);
    if (!storeDone) reportTimeout("store with a pulse while busy");
    repeat (6) begin
      @(negedge clk);
      checkFlag(1'b0, storeDone, "extra store done");
    end
    applyStore(32'h40, SizeWord, first);
    doLoad(32'h44, SizeWord, 1'b0);
    doLoad(32'h40, SizeWord, 1'b0);
  endtask

  // **************************************************************************
  // sequence
  // **************************************************************************

  initial begin
    logic [1:0]           kind;
    logic [SizeWidth-1:0] sSize;
    logic [SizeWidth-1:0] lSize;
    logic [DataWidth-1:0] sAddr;
    logic [DataWidth-1:0] lAddr;
    logic [DataWidth-1:0] sData;
    lfsr = 32'h8a12;
    for (int i = 0; i < RamDepth; i++) shadow[i] = '0;
    clk        = 1'b0;
    reset      = 1'b1;
    storeReq   = 1'b0;
    storeAddr  = '0;
    storeSize  = SizeWord;
    storeData  = '0;
    loadReq    = 1'b0;
    loadAddr   = '0;
    loadSize   = SizeWord;
    loadSigned = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkFlag(1'b0, storeBusy | storeDone | storeAddrErr, "store outputs after reset");
    checkFlag(1'b0, loadBusy | loadDone | loadAddrErr, "load outputs after reset");
    checkWord('0, loadData, "load data after reset");
    for (int n = 0; n < TxnCount; n++) begin
      kind  = 2'(nextBits(2));
      sSize = randomSize();
      lSize = randomSize();
      sAddr = randomAddr(sSize);
      lAddr = randomAddr(lSize);
      sData = nextBits(32);
      case (kind)
        2'd0: doStore(sAddr, sSize, sData);
        2'd1: doLoad(lAddr, lSize, nextBits(1) != 32'd0);
        2'd2: doBoth(sAddr, sSize, sData, lAddr, lSize, nextBits(1) != 32'd0);
        default: begin
          doStore(sAddr, sSize, sData);
          doLoad(sAddr & ~32'h3, SizeWord, 1'b0);
        end
      endcase
    end
    storeWhileBusy(nextBits(32), nextBits(32));
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* src/dataRam.sv */
// single-port data RAM with per-byte write enables and a registered read
`timescale 1ns/1ns
`default_nettype none

module dataRam (
  input  logic                                 clk,
  input  logic [ramPkg::WordAddrWidth-1:0]     addr,
  input  logic [memAccessPkg::LaneCount-1:0]   wen,
  input  ramPkg::ramWord                       wdata,
  output ramPkg::ramWord                       rdata
);

  import memAccessPkg::*;
  import ramPkg::*;

  ramWord mem [RamDepth];

  initial begin
    for (int i = 0; i < RamDepth; i++) begin
      mem[i] = '0;
    end
  end

  // a read in the same cycle as a write returns the old word
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < LaneCount; lane++) begin
      if (wen[lane]) begin
        mem[addr].bytes[lane] <= wdata.bytes[lane];
      end
    end
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

/* src/loadPath.sv */
// load path that memStage uses to check alignment, read the RAM and extend the result
`timescale 1ns/1ns
`default_nettype none

module loadPath (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 loadReq,
  input  logic [memAccessPkg::DataWidth-1:0]   loadAddr,
  input  logic [memAccessPkg::SizeWidth-1:0]   loadSize,
  input  logic                                 loadSigned,
  input  logic                                 grant,
  input  ramPkg::ramWord                       ramRdata,
  output logic                                 ramReq,
  output logic [ramPkg::WordAddrWidth-1:0]     ramAddr,
  output logic                                 loadBusy,
  output logic                                 loadDone,
  output logic                                 loadAddrErr,
  output logic [memAccessPkg::DataWidth-1:0]   loadData
);

  import memAccessPkg::*;
  import ramPkg::*;

  logic                     pending;
  logic                     reading;
  logic                     misaligned;
  logic                     accept;
  logic [1:0]               lowQ;
  logic [SizeWidth-1:0]     sizeQ;
  logic                     signedQ;
  logic [WordAddrWidth-1:0] addrQ;
  logic [LaneWidth-1:0]     laneSel;
  logic [HalfWidth-1:0]     halfSel;
  logic [DataWidth-1:0]     extracted;

  assign misaligned = ((loadSize == SizeHalf) && loadAddr[0]) ||
                      ((loadSize == SizeWord) && (loadAddr[1:0] != 2'b00));

  assign accept = loadReq && !loadBusy && !misaligned && (loadSize != SizeNone);

  // ************************************************************************
  // result extraction
  // ************************************************************************

  assign laneSel = ramRdata.bytes[lowQ];
  assign halfSel = ramRdata.halves[lowQ[1]];

  // sign bit is only replicated when the load was signed
  always_comb begin
    case (sizeQ)
      SizeByte: begin
        extracted = {{(DataWidth-LaneWidth){signedQ & laneSel[LaneWidth-1]}}, laneSel};
      end
      SizeHalf: begin
        extracted = {{(DataWidth-HalfWidth){signedQ & halfSel[HalfWidth-1]}}, halfSel};
      end
      default: extracted = ramRdata;
    endcase
  end

  // ************************************************************************
  // request tracking
  // ************************************************************************

  // pending waits for the grant and reading covers the cycle in which the RAM word arrives
  always_ff @(posedge clk) begin
    if (reset) begin
      pending     <= 1'b0;
      reading     <= 1'b0;
      loadDone    <= 1'b0;
      loadAddrErr <= 1'b0;
      loadData    <= '0;
    end else begin
      loadAddrErr <= loadReq && !loadBusy && misaligned;
      reading     <= pending && grant;
      loadDone    <= reading;
      if (reading) begin
        loadData <= extracted;
      end
      if (accept) begin
        pending <= 1'b1;
      end else if (grant) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      lowQ    <= loadAddr[1:0];
      sizeQ   <= loadSize;
      signedQ <= loadSigned;
      addrQ   <= loadAddr[WordAddrWidth+1:2];
    end
  end

  assign ramReq   = pending;
  assign ramAddr  = addrQ;
  assign loadBusy = pending || reading;

endmodule

`default_nettype wire

/* src/memAccessPkg.sv */
// access size codes and data, lane and half widths shared by the store and load paths
`default_nettype none

package memAccessPkg;

  // ************************************************************************
  // word and lane geometry
  // ************************************************************************

  localparam int DataWidth = 32;
  localparam int LaneCount = 4;
  localparam int LaneWidth = DataWidth / LaneCount;
  localparam int HalfCount = 2;
  localparam int HalfWidth = DataWidth / HalfCount;

  // ************************************************************************
  // access size encoding
  // ************************************************************************

  localparam int SizeWidth = 2;

  localparam logic [SizeWidth-1:0] SizeByte = 2'd0;
  localparam logic [SizeWidth-1:0] SizeHalf = 2'd1;
  localparam logic [SizeWidth-1:0] SizeWord = 2'd2;

  // the spare code means no access at all, so it raises no error and writes nothing
  localparam logic [SizeWidth-1:0] SizeNone = 2'd3;

endpackage

`default_nettype wire

/* src/memArbiter.sv */
// fixed-priority arbiter that puts one of the load and store paths on the RAM port per cycle
`timescale 1ns/1ns
`default_nettype none

module memArbiter (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 loadReq,
  input  logic                                 storeReq,
  input  logic [ramPkg::WordAddrWidth-1:0]     loadAddr,
  input  logic [ramPkg::WordAddrWidth-1:0]     storeAddr,
  input  logic [memAccessPkg::LaneCount-1:0]   storeWen,
  input  ramPkg::ramWord                       storeWdata,
  output logic                                 loadGrant,
  output logic                                 storeGrant,
  output logic [ramPkg::WordAddrWidth-1:0]     ramAddr,
  output logic [memAccessPkg::LaneCount-1:0]   ramWen,
  output ramPkg::ramWord                       ramWdata
);

  logic loadEligible;
  logic storeEligible;

  // a path still holds its request during its grant cycle, so it is masked for that cycle
  assign loadEligible  = loadReq && !loadGrant;
  assign storeEligible = storeReq && !storeGrant;

  // load wins whenever both are waiting
  always_ff @(posedge clk) begin
    if (reset) begin
      loadGrant  <= 1'b0;
      storeGrant <= 1'b0;
    end else begin
      loadGrant  <= loadEligible;
      storeGrant <= storeEligible && !loadEligible;
    end
  end

  // ************************************************************************
  // RAM port steering
  // ************************************************************************

  assign ramAddr  = loadGrant ? loadAddr : storeAddr;
  assign ramWen   = storeGrant ? storeWen : '0;
  // write data only matters when the enables are set
  assign ramWdata = storeWdata;

endmodule

`default_nettype wire

/* src/memStage.sv */
// top level of the data memory stage that joins the store and load paths to one shared RAM
`timescale 1ns/1ns
`default_nettype none

module memStage (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 storeReq,
  input  logic [memAccessPkg::DataWidth-1:0]   storeAddr,
  input  logic [memAccessPkg::SizeWidth-1:0]   storeSize,
  input  logic [memAccessPkg::DataWidth-1:0]   storeData,
  output logic                                 storeBusy,
  output logic                                 storeDone,
  output logic                                 storeAddrErr,
  input  logic                                 loadReq,
  input  logic [memAccessPkg::DataWidth-1:0]   loadAddr,
  input  logic [memAccessPkg::SizeWidth-1:0]   loadSize,
  input  logic                                 loadSigned,
  output logic                                 loadBusy,
  output logic                                 loadDone,
  output logic [memAccessPkg::DataWidth-1:0]   loadData,
  output logic                                 loadAddrErr
);

  import memAccessPkg::*;
  import ramPkg::*;

  logic                     storeRamReq;
  logic [WordAddrWidth-1:0] storeRamAddr;
  logic [LaneCount-1:0]     storeRamWen;
  ramWord                   storeRamWdata;
  logic                     storeGrant;
  logic                     loadRamReq;
  logic [WordAddrWidth-1:0] loadRamAddr;
  logic                     loadGrant;
  logic [WordAddrWidth-1:0] ramAddr;
  logic [LaneCount-1:0]     ramWen;
  ramWord                   ramWdata;
  ramWord                   ramRdata;

  storePath u_storePath (
    .clk          (clk),
    .reset        (reset),
    .storeReq     (storeReq),
    .storeAddr    (storeAddr),
    .storeSize    (storeSize),
    .storeData    (storeData),
    .grant        (storeGrant),
    .ramReq       (storeRamReq),
    .ramAddr      (storeRamAddr),
    .ramWen       (storeRamWen),
    .ramWdata     (storeRamWdata),
    .storeBusy    (storeBusy),
    .storeDone    (storeDone),
    .storeAddrErr (storeAddrErr)
  );

  loadPath u_loadPath (
    .clk         (clk),
    .reset       (reset),
    .loadReq     (loadReq),
    .loadAddr    (loadAddr),
    .loadSize    (loadSize),
    .loadSigned  (loadSigned),
    .grant       (loadGrant),
    .ramRdata    (ramRdata),
    .ramReq      (loadRamReq),
    .ramAddr     (loadRamAddr),
    .loadBusy    (loadBusy),
    .loadDone    (loadDone),
    .loadAddrErr (loadAddrErr),
    .loadData    (loadData)
  );

  memArbiter u_memArbiter (
    .clk        (clk),
    .reset      (reset),
    .loadReq    (loadRamReq),
    .storeReq   (storeRamReq),
    .loadAddr   (loadRamAddr),
    .storeAddr  (storeRamAddr),
    .storeWen   (storeRamWen),
    .storeWdata (storeRamWdata),
    .loadGrant  (loadGrant),
    .storeGrant (storeGrant),
    .ramAddr    (ramAddr),
    .ramWen     (ramWen),
    .ramWdata   (ramWdata)
  );

  dataRam u_dataRam (
    .clk   (clk),
    .addr  (ramAddr),
    .wen   (ramWen),
    .wdata (ramWdata),
    .rdata (ramRdata)
  );

endmodule

`default_nettype wire

/* src/ramPkg.sv */
// data RAM geometry and the word type that is read either as bytes or as halves
`default_nettype none

package ramPkg;

  localparam int RamDepth = 256;

  // word index comes from byte address bits 9 to 2
  localparam int WordAddrWidth = $clog2(RamDepth);

  // one RAM word is read lane by lane for byte accesses and in two halves for half accesses
  typedef union packed {
    logic [memAccessPkg::LaneCount-1:0][memAccessPkg::LaneWidth-1:0] bytes;
    logic [memAccessPkg::HalfCount-1:0][memAccessPkg::HalfWidth-1:0] halves;
  } ramWord;

endpackage

`default_nettype wire

/* src/storePath.sv */
// store path that memStage uses to check alignment, build byte enables and replicate data
`timescale 1ns/1ns
`default_nettype none

module storePath (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 storeReq,
  input  logic [memAccessPkg::DataWidth-1:0]   storeAddr,
  input  logic [memAccessPkg::SizeWidth-1:0]   storeSize,
  input  logic [memAccessPkg::DataWidth-1:0]   storeData,
  input  logic                                 grant,
  output logic                                 ramReq,
  output logic [ramPkg::WordAddrWidth-1:0]     ramAddr,
  output logic [memAccessPkg::LaneCount-1:0]   ramWen,
  output ramPkg::ramWord                       ramWdata,
  output logic                                 storeBusy,
  output logic                                 storeDone,
  output logic                                 storeAddrErr
);

  import memAccessPkg::*;
  import ramPkg::*;

  logic                     pending;
  logic                     misaligned;
  logic                     accept;
  logic [LaneCount-1:0]     laneEn;
  ramWord                   laneData;
  logic [LaneCount-1:0]     wenQ;
  logic [WordAddrWidth-1:0] addrQ;
  ramWord                   dataQ;

  // ************************************************************************
  // request decode
  // ************************************************************************

  // byte enables from size and the low address bits
  always_comb begin
    case (storeSize)
      SizeWord: laneEn = '1;
      SizeHalf: laneEn = storeAddr[1] ? 4'b1100 : 4'b0011;
      SizeByte: laneEn = LaneCount'(1) << storeAddr[1:0];
      default:  laneEn = '0;
    endcase
  end

  assign misaligned = ((storeSize == SizeHalf) && storeAddr[0]) ||
                      ((storeSize == SizeWord) && (storeAddr[1:0] != 2'b00));

  // the low byte or half goes onto every lane and the enables then pick the one that is written
  always_comb begin
    case (storeSize)
      SizeByte: begin
        for (int i = 0; i < LaneCount; i++) begin
          laneData.bytes[i] = storeData[LaneWidth-1:0];
        end
      end
      SizeHalf: begin
        for (int i = 0; i < HalfCount; i++) begin
          laneData.halves[i] = storeData[HalfWidth-1:0];
        end
      end
      default: laneData = storeData;
    endcase
  end

  // a request while busy is dropped, and the spare size code never gets this far
  assign accept = storeReq && !pending && !misaligned && (laneEn != '0);

  // ************************************************************************
  // request hold and completion
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      pending      <= 1'b0;
      storeDone    <= 1'b0;
      storeAddrErr <= 1'b0;
    end else begin
      storeAddrErr <= storeReq && !pending && misaligned;
      // the write lands at the end of the grant cycle
      storeDone    <= pending && grant;
      if (accept) begin
        pending <= 1'b1;
      end else if (grant) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wenQ  <= laneEn;
      addrQ <= storeAddr[WordAddrWidth+1:2];
      dataQ <= laneData;
    end
  end

  assign ramReq    = pending;
  assign storeBusy = pending;
  assign ramAddr   = addrQ;
  assign ramWen    = wenQ;
  assign ramWdata  = dataQ;

endmodule

`default_nettype wire
